// ==== design/i2s_audio_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2s_audio_top
	import i2s_pkg::*;
(
	input  wire			h2f_clk0,
	input  wire			h2f_nrst,

	// ======================================================================
	// playback FIFO, show-ahead
	// ======================================================================
	input  wire			play_enable,
	input  wire			play_empty,
	input  wire i2s_frame_t	play_frame,
	output logic		play_read,

	// ======================================================================
	// capture FIFO
	// ======================================================================
	input  wire			cap_enable,
	input  wire			cap_full,
	output i2s_frame_t	cap_frame,
	output logic		cap_write,

	// ======================================================================
	// I2S pins, master mode
	// ======================================================================
	input  wire			din,
	output logic		bclk,
	output logic		lrclk,
	output logic		dout
);

	i2s_slot_t	slot;		// timing marks to all blocks
	logic		load;		// serializer reload
	logic		load_mute;	// reload with zeros

	// bclk, lrclk and slot marks
	i2s_clock_gen u_clock_gen (
		.h2f_clk0	(h2f_clk0),
		.h2f_nrst	(h2f_nrst),
		.slot		(slot),
		.bclk		(bclk),
		.lrclk		(lrclk)
	);

	// FIFO strobes and capture FSM
	i2s_xfer_ctrl u_xfer_ctrl (
		.h2f_clk0		(h2f_clk0),
		.h2f_nrst		(h2f_nrst),
		.slot			(slot),
		.play_enable	(play_enable),
		.play_empty		(play_empty),
		.play_read		(play_read),
		.load			(load),
		.load_mute		(load_mute),
		.cap_enable		(cap_enable),
		.cap_full		(cap_full),
		.cap_write		(cap_write)
	);

	// playback serializer
	i2s_shift_out u_shift_out (
		.h2f_clk0	(h2f_clk0),
		.h2f_nrst	(h2f_nrst),
		.slot		(slot),
		.load		(load),
		.load_mute	(load_mute),
		.play_frame	(play_frame),
		.dout		(dout)
	);

	// capture deserializer
	i2s_shift_in u_shift_in (
		.h2f_clk0	(h2f_clk0),
		.h2f_nrst	(h2f_nrst),
		.slot		(slot),
		.din		(din),
		.cap_frame	(cap_frame)
	);

endmodule

`default_nettype wire

// ==== design/i2s_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "i2s_defines.svh"

module i2s_clock_gen
	import i2s_pkg::*;
(
	input  wire		h2f_clk0,
	input  wire		h2f_nrst,
	output i2s_slot_t	slot,	// marks and slot index
	output logic		bclk,
	output logic		lrclk
);

	localparam int HALF		= `I2S_BCLK_HALF;
	localparam int HCNT_W	= (HALF > 1) ? $clog2(HALF) : 1;
	localparam int IDX_W	= $clog2(`I2S_FRAME_BITS);
	localparam int LAST		= `I2S_FRAME_BITS - 1;	// slot 63
	localparam int LR_FIRST	= `I2S_SAMPLE_W - 1;	// lrclk high from slot 31
	localparam int LR_LAST	= `I2S_FRAME_BITS - 2;	// ... to slot 62

	logic [HCNT_W-1:0]	hcnt;		// cycles into the bclk half
	logic [IDX_W-1:0]	idx_q;		// current slot
	logic [IDX_W-1:0]	idx_nxt;	// slot opened by the next fall
	logic				half_done;	// last cycle of a half period
	logic				fall_q;
	logic				rise_q;

	assign half_done = (hcnt == HCNT_W'(HALF - 1));
	assign idx_nxt = (idx_q == IDX_W'(LAST)) ? '0 : idx_q + 1'b1;	// wrap at 64

	// ======================================================================
	// bclk divider and slot counter
	// ======================================================================
	always_ff @(posedge h2f_clk0 or negedge h2f_nrst) begin
		if (!h2f_nrst) begin
			hcnt	<= '0;
			bclk	<= 1'b0;	// idle low
			lrclk	<= 1'b0;
			idx_q	<= '0;
			fall_q	<= 1'b0;
			rise_q	<= 1'b0;
		end else begin
			fall_q <= 1'b0;	// marks are single cycle
			rise_q <= 1'b0;
			if (half_done) begin
				hcnt <= '0;
				bclk <= ~bclk;
				if (bclk) begin	// high to low, a slot begins
					fall_q	<= 1'b1;
					idx_q	<= idx_nxt;
					// lrclk moves with bclk fall, one slot ahead of the MSB
					lrclk	<= (idx_nxt >= IDX_W'(LR_FIRST)) && (idx_nxt <= IDX_W'(LR_LAST));
				end else begin
					rise_q	<= 1'b1;	// low to high, sample point
				end
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// marks line up with the bclk level they announce
	assign slot = '{bclk_fall: fall_q, bclk_rise: rise_q, index: idx_q};

	// every fall is followed by a rise one half period later
	a_fall_then_rise: assert property (@(posedge h2f_clk0) disable iff (!h2f_nrst)
		slot.bclk_fall |-> !slot.bclk_rise ##HALF slot.bclk_rise);

endmodule

`default_nettype wire

// ==== design/i2s_defines.svh ====
`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

// ======================================================================
// serial audio timing constants
// ======================================================================

// bits in one channel sample
`define I2S_SAMPLE_W	32

// bit slots per lrclk period, left plus right
`define I2S_FRAME_BITS	64

// h2f_clk0 cycles per bclk half-period, 1 or more
`define I2S_BCLK_HALF	2

`endif

// ==== design/i2s_pkg.sv ====
`default_nettype none

`include "i2s_defines.svh"

package i2s_pkg;

	// ======================================================================
	// stereo frame as held by the FIFOs
	// ======================================================================
	typedef struct packed {
		logic [`I2S_SAMPLE_W-1:0]	left;	// goes out first, bits 63..32
		logic [`I2S_SAMPLE_W-1:0]	right;	// bits 31..0
	} i2s_frame_t;

	// ======================================================================
	// bit timing marks from the clock generator
	// ======================================================================
	typedef struct packed {
		logic	bclk_fall;	// first cycle of a new slot
		logic	bclk_rise;	// mid slot, data sample point
		logic [$clog2(`I2S_FRAME_BITS)-1:0]	index;	// slot 0..63
	} i2s_slot_t;

	// capture machine
	typedef enum logic [1:0] {
		XFER_IDLE,	// capture off
		XFER_ARM,	// enabled, waiting for slot 0
		XFER_RUN	// whole frames go to the FIFO
	} xfer_state_e;

endpackage

`default_nettype wire

// ==== design/i2s_shift_in.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "i2s_defines.svh"

module i2s_shift_in
	import i2s_pkg::*;
(
	input  wire			h2f_clk0,
	input  wire			h2f_nrst,
	input  wire i2s_slot_t	slot,
	input  wire			din,
	output i2s_frame_t	cap_frame	// last whole frame
);

	localparam int MSB	= `I2S_FRAME_BITS - 1;
	localparam int IDX_W	= $clog2(`I2S_FRAME_BITS);

	logic [MSB:0]	asm_q;		// frame under assembly
	logic			last_slot;	// sampling the right LSB

	assign last_slot = (slot.index == IDX_W'(MSB));

	// ======================================================================
	// deserializer, din sampled mid slot
	// ======================================================================
	always_ff @(posedge h2f_clk0 or negedge h2f_nrst) begin
		if (!h2f_nrst) begin
			asm_q		<= '0;
			cap_frame	<= '0;
		end else if (slot.bclk_rise) begin
			asm_q[MSB - slot.index] <= din;	// slot k lands in bit 63 - k
			if (last_slot)
				cap_frame <= {asm_q[MSB:1], din};	// hold until next frame
		end
	end

endmodule

`default_nettype wire

// ==== design/i2s_shift_out.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "i2s_defines.svh"

module i2s_shift_out
	import i2s_pkg::*;
(
	input  wire			h2f_clk0,
	input  wire			h2f_nrst,
	input  wire i2s_slot_t	slot,
	input  wire			load,		// slot 63 fall
	input  wire			load_mute,	// no frame this period
	input  wire i2s_frame_t	play_frame,	// show-ahead FIFO head
	output logic		dout
);

	localparam int MSB = `I2S_FRAME_BITS - 1;

	logic [MSB:0]	hold;	// next frame to send
	logic [MSB:0]	shreg;	// bits left in the current frame

	// ======================================================================
	// holding register, filled one slot before the frame starts
	// ======================================================================
	always_ff @(posedge h2f_clk0) begin
		if (load)
			hold <= load_mute ? '0 : play_frame;	// silence on underrun
	end

	// ======================================================================
	// serializer, one bit per slot, MSB first
	// ======================================================================
	always_ff @(posedge h2f_clk0 or negedge h2f_nrst) begin
		if (!h2f_nrst) begin
			dout	<= 1'b0;
			shreg	<= '0;
		end else if (slot.bclk_fall) begin
			if (slot.index == '0) begin	// new frame, left MSB
				dout	<= hold[MSB];
				shreg	<= {hold[MSB-1:0], 1'b0};
			end else begin
				dout	<= shreg[MSB];	// bit 63 - slot
				shreg	<= {shreg[MSB-1:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/i2s_xfer_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "i2s_defines.svh"

module i2s_xfer_ctrl
	import i2s_pkg::*;
(
	input  wire			h2f_clk0,
	input  wire			h2f_nrst,
	input  wire i2s_slot_t	slot,

	// playback side
	input  wire			play_enable,
	input  wire			play_empty,
	output logic		play_read,	// pops one frame
	output logic		load,		// serializer takes a frame
	output logic		load_mute,	// ... or zeros

	// capture side
	input  wire			cap_enable,
	input  wire			cap_full,
	output logic		cap_write	// pushes cap_frame
);

	localparam int IDX_W	= $clog2(`I2S_FRAME_BITS);
	localparam int LAST		= `I2S_FRAME_BITS - 1;
	localparam int SLOT_CYC	= 2 * `I2S_BCLK_HALF;	// h2f_clk0 cycles per slot
	localparam int WHOLE_CYC	= LAST * SLOT_CYC + `I2S_BCLK_HALF;	// first RUN cycle to push

	logic			frame_edge;	// fall that opens slot 63
	logic			frame_mid;	// rise inside slot 63
	logic			slot0_edge;	// fall that opens slot 0
	logic			pop;
	logic			wr_pend;	// frame complete, write next cycle
	xfer_state_e	state;
	xfer_state_e	state_nxt;

	assign frame_edge	= slot.bclk_fall && (slot.index == IDX_W'(LAST));
	assign frame_mid	= slot.bclk_rise && (slot.index == IDX_W'(LAST));
	assign slot0_edge	= slot.bclk_fall && (slot.index == '0);

	// ======================================================================
	// playback, one pop per lrclk period at most
	// ======================================================================
	assign pop			= frame_edge & play_enable & ~play_empty;	// flags gate the strobe
	assign play_read	= pop;
	assign load			= frame_edge;	// serializer reloads every period
	assign load_mute	= frame_edge & ~pop;	// nothing popped, send silence

	// ======================================================================
	// capture FSM
	// ======================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			XFER_IDLE: begin
				if (cap_enable)
					state_nxt = XFER_ARM;
			end
			XFER_ARM: begin
				if (!cap_enable)
					state_nxt = XFER_IDLE;
				else if (slot0_edge)	// align to a frame start
					state_nxt = XFER_RUN;
			end
			XFER_RUN: begin
				if (!cap_enable)
					state_nxt = XFER_IDLE;
			end
			default: state_nxt = XFER_IDLE;
		endcase
	end

	always_ff @(posedge h2f_clk0 or negedge h2f_nrst) begin
		if (!h2f_nrst) begin
			state	<= XFER_IDLE;
			wr_pend	<= 1'b0;
		end else begin
			state	<= state_nxt;
			wr_pend	<= (state == XFER_RUN) && frame_mid;	// last bit sampled now
		end
	end

	// full drops the frame, no retry
	assign cap_write = wr_pend & ~cap_full;

	// a pop is followed one slot later by the slot 0 fall that sends its MSB
	a_pop_then_slot0: assert property (@(posedge h2f_clk0) disable iff (!h2f_nrst)
		play_read |-> !play_empty ##SLOT_CYC slot0_edge);

	// a push needs capture running since the start of its frame
	a_push_whole_frame: assert property (@(posedge h2f_clk0) disable iff (!h2f_nrst)
		cap_write |-> $past(state == XFER_RUN, WHOLE_CYC));

endmodule

`default_nettype wire

// ==== i2s_audio.f ====
+incdir+design
design/i2s_pkg.sv
design/i2s_clock_gen.sv
design/i2s_xfer_ctrl.sv
design/i2s_shift_out.sv
design/i2s_shift_in.sv
design/i2s_audio_top.sv
verification/tb_i2s_audio.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the I2S audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_i2s_audio
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir "$OBJ" -f i2s_audio.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see $LOG"
exit 1

// ==== verification/tb_i2s_audio.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "i2s_defines.svh"

module tb_i2s_audio
	import i2s_pkg::*;
();

	localparam int HALF			= `I2S_BCLK_HALF;
	localparam int SW			= `I2S_SAMPLE_W;
	localparam int NBITS		= `I2S_FRAME_BITS;
	localparam int PERIOD_CYC	= NBITS * 2 * HALF;	// one lrclk period
	localparam int RUN_CYC		= 32 * PERIOD_CYC;
	localparam int N_FRAMES		= 20;	// preloaded, runs dry near the end
	localparam int MIN_CAPS		= 16;
	localparam int CAP_WAIT		= 4 * PERIOD_CYC;

	logic			h2f_clk0 = 1'b0;
	logic			h2f_nrst;
	logic			play_enable;
	logic			play_empty;
	i2s_frame_t		play_frame;
	logic			play_read;
	logic			cap_enable;
	logic			cap_full;
	i2s_frame_t		cap_frame;
	logic			cap_write;
	logic			bclk;
	logic			lrclk;
	logic			dout;

	i2s_frame_t		play_q[$];	// playback FIFO contents
	logic [31:0]	lfsr_q;
	logic			gap;		// forced empty window
	int				val_err;
	int				to_err;
	int				n_bits;		// dout bits compared
	int				n_caps;		// frames compared

	// monitor state
	logic			bclk_q;
	logic			lrclk_q;
	int				tb_slot;	// slot index seen from the pins
	int				since_fall;	// cycles since last bclk fall
	logic			seen_fall;
	i2s_frame_t		cur_frame;	// frame on dout this period
	i2s_frame_t		next_frame;	// taken at slot 63
	logic			wr_due;		// capture push expected this cycle
	logic			armed;
	logic			running;	// capture takes whole frames

	i2s_audio_top DUT (
		.h2f_clk0		(h2f_clk0),
		.h2f_nrst		(h2f_nrst),
		.play_enable	(play_enable),
		.play_empty		(play_empty),
		.play_frame		(play_frame),
		.play_read		(play_read),
		.cap_enable		(cap_enable),
		.cap_full		(cap_full),
		.cap_frame		(cap_frame),
		.cap_write		(cap_write),
		.din			(dout),	// loopback
		.bclk			(bclk),
		.lrclk			(lrclk),
		.dout			(dout)
	);

	initial begin : clock_gen
		forever #5 h2f_clk0 = ~h2f_clk0;	// 100 MHz
	end

	// ======================================================================
	// LFSR, reference bit and reporting
	// ======================================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);	// one step per bit
			v = {v[62:0], lfsr_q[0]};
		end
	endtask

	// slot k carries bit 63-k, left sample in slots 0..31
	function automatic logic frame_bit(input i2s_frame_t f, input int k);
		if (k < SW)
			return f.left[SW-1-k];
		return f.right[NBITS-1-k];
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		val_err++;
		$display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
	endtask

	// ======================================================================
	// playback FIFO pop, taken on the strobe
	// ======================================================================
	always @(posedge h2f_clk0) begin : fifo_pop
		if (play_read) begin
			assert (play_q.size() != 0) else begin
				val_err++;
				$display("play_read popped the playback FIFO while it was empty at %0t", $time);
			end
			if (play_q.size() != 0)
				play_q.delete(0);
		end
	end

	// ======================================================================
	// monitor, pre-edge values of each cycle
	// ======================================================================
	always @(posedge h2f_clk0) begin : monitor
		logic	fell;
		logic	rose;
		logic	pr_exp;
		logic	cw_exp;
		logic	lr_exp;
		if (!h2f_nrst) begin
			bclk_q		= 1'b0;
			lrclk_q		= 1'b0;
			tb_slot		= 0;	// index starts at 0
			since_fall	= 0;
			seen_fall	= 1'b0;
			cur_frame	= '0;	// serializer starts empty
			next_frame	= '0;
			wr_due		= 1'b0;
			armed		= 1'b0;
			running		= 1'b0;
		end else begin
			fell = bclk_q & ~bclk;
			rose = ~bclk_q & bclk;
			since_fall++;

			// push of the frame that just ended, before slot 0 moves on
			cw_exp = wr_due & ~cap_full;
			assert (cap_write == cw_exp) else report_mismatch("cap_write", cap_write, cw_exp);
			if (cap_write && cw_exp) begin
				n_caps++;
				assert (cap_frame == cur_frame) else
					report_mismatch("cap_frame", cap_frame, cur_frame);
			end
			wr_due = 1'b0;

			if (fell) begin
				if (seen_fall) begin
					assert (since_fall == 2 * HALF) else
						report_mismatch("bclk period", since_fall, 2 * HALF);
				end
				seen_fall	= 1'b1;
				since_fall	= 0;
				tb_slot		= (tb_slot == NBITS - 1) ? 0 : tb_slot + 1;
				if (tb_slot == 0)
					cur_frame = next_frame;
				if (tb_slot == NBITS - 1)	// pop or silence for the next period
					next_frame = (play_enable && !play_empty) ? play_frame : '0;
				lr_exp = (tb_slot >= SW - 1) && (tb_slot <= NBITS - 2);
				assert (lrclk == lr_exp) else report_mismatch("lrclk", lrclk, lr_exp);
			end else begin
				assert (lrclk == lrclk_q) else
					report_mismatch("lrclk away from bclk fall", lrclk, lrclk_q);
			end

			if (rose) begin
				if (seen_fall) begin
					assert (since_fall == HALF) else
						report_mismatch("bclk high phase", since_fall, HALF);
				end
				assert (dout == frame_bit(cur_frame, tb_slot)) else
					report_mismatch($sformatf("dout slot %0d", tb_slot), dout,
						frame_bit(cur_frame, tb_slot));
				n_bits++;
				if (tb_slot == NBITS - 1)
					wr_due = running;	// last bit sampled now
			end

			pr_exp = fell && (tb_slot == NBITS - 1) && play_enable && !play_empty;
			assert (play_read == pr_exp) else report_mismatch("play_read", play_read, pr_exp);

			// capture arms a cycle after enable, runs from the next slot 0
			if (!cap_enable) begin
				armed	= 1'b0;
				running	= 1'b0;
			end else if (!armed) begin
				armed = 1'b1;
			end else if (fell && tb_slot == 0) begin
				running = 1'b1;
			end

			bclk_q	= bclk;
			lrclk_q	= lrclk;
		end
	end

	// ======================================================================
	// stimulus, inputs change on the falling edge
	// ======================================================================
	task automatic drive_inputs(input int cyc);
		logic [63:0]	r;
		if (cyc % 64 == 0) begin
			draw_bits(9, r);
			play_enable	= (r[2:0] != 3'd0);	// mostly on
			cap_full	= (r[5:3] == 3'd0);
			gap			= (r[8:6] == 3'd0);
		end
		if (cyc == 2 * PERIOD_CYC + 37)
			cap_enable = 1'b1;	// mid frame
		else if (cyc == 14 * PERIOD_CYC + 100)
			cap_enable = 1'b0;
		else if (cyc == 16 * PERIOD_CYC + 5)
			cap_enable = 1'b1;
		play_empty	= (play_q.size() == 0) || gap;
		play_frame	= (play_q.size() != 0) ? play_q[0] : '0;	// show-ahead head
	endtask

	initial begin : stimulus
		logic [63:0]	r;
		int				wait_cyc;
		h2f_nrst	= 1'b0;
		play_enable	= 1'b0;
		play_empty	= 1'b1;
		play_frame	= '0;
		cap_enable	= 1'b0;
		cap_full	= 1'b0;
		gap			= 1'b0;
		val_err		= 0;
		to_err		= 0;
		n_bits		= 0;
		n_caps		= 0;
		lfsr_q		= 32'h2ce74259;
		for (int i = 0; i < N_FRAMES; i++) begin
			draw_bits(NBITS, r);
			play_q.push_back(r);
		end
		repeat (4) @(negedge h2f_clk0);
		// outputs settled low after the reset edges
		assert (!bclk && !lrclk && !dout && !play_read && !cap_write) else
			report_mismatch("outputs in reset", {bclk, lrclk, dout, play_read, cap_write}, '0);
		h2f_nrst = 1'b1;
		for (int cyc = 0; cyc < RUN_CYC; cyc++) begin
			@(negedge h2f_clk0);
			drive_inputs(cyc);
		end
		wait_cyc = 0;
		while (n_caps < MIN_CAPS && wait_cyc < CAP_WAIT) begin
			@(negedge h2f_clk0);
			drive_inputs(RUN_CYC + wait_cyc);
			wait_cyc++;
		end
		if (n_caps < MIN_CAPS) begin
			to_err++;
			$display("timeout waiting for captured frames, only %0d of %0d arrived",
				n_caps, MIN_CAPS);
		end
		$display("errors: %0d value, %0d timeout; %0d dout bits, %0d frames compared",
			val_err, to_err, n_bits, n_caps);
		if (val_err == 0 && to_err == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
